//--- build.f
source/kmeans_pkg.sv
source/point_mem.sv
source/centroid_bank.sv
source/nearest_centroid.sv
source/cluster_accum.sv
source/kmeans_ctrl.sv
source/kmeans_top.sv
verification/kmeans_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module kmeans_tb \
  -f build.f -o kmeans_sim

./obj_dir/kmeans_sim | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

//--- source/centroid_bank.sv
`timescale 1ns/1ps

module centroid_bank
  import kmeans_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         load_en,
  input  cluster_idx_t load_idx,
  input  point_t       load_data,
  input  logic         snapshot_en,
  input  logic         update_en,
  input  sum_t         sum_x0,
  input  sum_t         sum_x1,
  input  sum_t         sum_x2,
  input  sum_t         sum_x3,
  input  sum_t         sum_y0,
  input  sum_t         sum_y1,
  input  sum_t         sum_y2,
  input  sum_t         sum_y3,
  input  count_t       count0,
  input  count_t       count1,
  input  count_t       count2,
  input  count_t       count3,
  output point_t       centroid0,
  output point_t       centroid1,
  output point_t       centroid2,
  output point_t       centroid3,
  output logic         converged,
  input  cluster_idx_t out_sel,
  output point_t       out_data
);

  point_t cur  [NUM_CLUSTERS];
  point_t prev [NUM_CLUSTERS];
  sum_t   sx   [NUM_CLUSTERS];
  sum_t   sy   [NUM_CLUSTERS];
  count_t cnt  [NUM_CLUSTERS];

  assign sx  = '{sum_x0, sum_x1, sum_x2, sum_x3};
  assign sy  = '{sum_y0, sum_y1, sum_y2, sum_y3};
  assign cnt = '{count0, count1, count2, count3};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_CLUSTERS; i++) begin
        cur[i] <= '0;
      end
    end else if (load_en) begin
      cur[load_idx] <= load_data;
    end else if (update_en) begin
      // truncated mean, empty clusters stay put
      for (int i = 0; i < NUM_CLUSTERS; i++) begin
        if (cnt[i] != '0) begin
          cur[i] <= {coord_t'(sx[i] / cnt[i]), coord_t'(sy[i] / cnt[i])};
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (snapshot_en) begin
      prev <= cur;
    end
  end

  always_comb begin
    converged = 1'b1;
    for (int i = 0; i < NUM_CLUSTERS; i++) begin
      if (cur[i] != prev[i]) begin
        converged = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_data <= '0;
    end else begin
      out_data <= cur[out_sel];
    end
  end

  assign centroid0 = cur[0];
  assign centroid1 = cur[1];
  assign centroid2 = cur[2];
  assign centroid3 = cur[3];

  a_load_vs_update: assert property (@(posedge clk) disable iff (!rst_n)
    !(load_en && update_en));

endmodule

//--- source/cluster_accum.sv
`timescale 1ns/1ps

module cluster_accum
  import kmeans_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         acc_clear,
  input  logic         assign_valid,
  input  cluster_idx_t assign_idx,
  input  point_t       assign_point,
  output sum_t         sum_x0,
  output sum_t         sum_x1,
  output sum_t         sum_x2,
  output sum_t         sum_x3,
  output sum_t         sum_y0,
  output sum_t         sum_y1,
  output sum_t         sum_y2,
  output sum_t         sum_y3,
  output count_t       count0,
  output count_t       count1,
  output count_t       count2,
  output count_t       count3
);

  sum_t   sx  [NUM_CLUSTERS];
  sum_t   sy  [NUM_CLUSTERS];
  count_t cnt [NUM_CLUSTERS];

  always_ff @(posedge clk) begin
    if (!rst_n || acc_clear) begin
      for (int i = 0; i < NUM_CLUSTERS; i++) begin
        sx[i]  <= '0;
        sy[i]  <= '0;
        cnt[i] <= '0;
      end
    end else if (assign_valid) begin
      // x from the upper byte, y from the lower
      sx[assign_idx]  <= sx[assign_idx] + sum_t'(assign_point[15:8]);
      sy[assign_idx]  <= sy[assign_idx] + sum_t'(assign_point[7:0]);
      cnt[assign_idx] <= cnt[assign_idx] + 1'b1;
    end
  end

  assign sum_x0 = sx[0];
  assign sum_x1 = sx[1];
  assign sum_x2 = sx[2];
  assign sum_x3 = sx[3];
  assign sum_y0 = sy[0];
  assign sum_y1 = sy[1];
  assign sum_y2 = sy[2];
  assign sum_y3 = sy[3];
  assign count0 = cnt[0];
  assign count1 = cnt[1];
  assign count2 = cnt[2];
  assign count3 = cnt[3];

  // a count past NUM_POINTS means a missed clear
  a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
    (cnt[0] <= count_t'(NUM_POINTS)) && (cnt[1] <= count_t'(NUM_POINTS)) &&
    (cnt[2] <= count_t'(NUM_POINTS)) && (cnt[3] <= count_t'(NUM_POINTS)));

endmodule

//--- source/kmeans_ctrl.sv
`timescale 1ns/1ps

module kmeans_ctrl
  import kmeans_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         in_valid,
  input  point_t       in_data,
  output addr_t        mem_addr,
  output logic         mem_we,
  output point_t       mem_wdata,
  output logic         load_en,
  output cluster_idx_t load_idx,
  output logic         snapshot_en,
  output logic         update_en,
  output logic         acc_clear,
  output logic         point_valid,
  input  logic         assign_valid,
  input  logic         converged,
  output cluster_idx_t out_sel,
  output logic         out_valid
);

  kmeans_state_t state;
  kmeans_state_t next_state;
  cluster_idx_t  init_cnt;
  addr_t         wr_addr;
  count_t        rd_cnt;
  count_t        done_cnt;
  logic [2:0]    phase;
  cluster_idx_t  out_cnt;
  logic          read_issue;
  logic          pass_done;

  // one read per five cycles, four scan plus one accumulate
  assign read_issue = (state == st_assign) && (phase == 3'd0) &&
                      (rd_cnt != count_t'(NUM_POINTS));
  assign pass_done  = (state == st_assign) && assign_valid &&
                      (done_cnt == count_t'(NUM_POINTS - 1));

  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (in_valid) begin
          next_state = st_load_init;
        end
      end
      st_load_init: begin
        if (init_cnt == cluster_idx_t'(NUM_CLUSTERS - 1)) begin
          next_state = st_load_data;
        end
      end
      st_load_data: begin
        if (!in_valid) begin
          next_state = st_assign;
        end
      end
      st_assign: begin
        if (pass_done) begin
          next_state = st_update;
        end
      end
      st_update: next_state = st_check;
      st_check:  next_state = converged ? st_output : st_assign;
      st_output: begin
        if (out_cnt == cluster_idx_t'(NUM_CLUSTERS - 1)) begin
          next_state = st_idle;
        end
      end
      default:   next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= st_idle;
      init_cnt    <= '0;
      wr_addr     <= '0;
      rd_cnt      <= '0;
      done_cnt    <= '0;
      phase       <= '0;
      out_cnt     <= '0;
      point_valid <= 1'b0;
      out_valid   <= 1'b0;
    end else begin
      state       <= next_state;
      init_cnt    <= load_en ? init_cnt + 1'b1 : '0;
      wr_addr     <= mem_we ? wr_addr + 1'b1 : (state == st_load_data ? wr_addr : '0);
      rd_cnt      <= (state != st_assign) ? '0 : rd_cnt + count_t'(read_issue);
      done_cnt    <= (state != st_assign) ? '0 : done_cnt + count_t'(assign_valid);
      phase       <= (state != st_assign || phase == 3'd4) ? '0 : phase + 1'b1;
      out_cnt     <= (state == st_output) ? out_cnt + 1'b1 : '0;
      // lines up with the memory's registered read data
      point_valid <= read_issue;
      out_valid   <= (state == st_output);
    end
  end

  assign mem_addr    = (state == st_load_data) ? wr_addr : addr_t'(rd_cnt);
  assign mem_we      = (state == st_load_data) && in_valid;
  assign mem_wdata   = in_data;
  assign load_en     = ((state == st_idle) && in_valid) || (state == st_load_init);
  assign load_idx    = init_cnt;
  assign snapshot_en = (state == st_update);
  assign update_en   = (state == st_update);
  assign acc_clear   = (next_state == st_assign) && (state != st_assign);
  assign out_sel     = out_cnt;

  // burst ends right after the last point, never early or late
  a_load_gap: assert property (@(posedge clk) disable iff (!rst_n)
    (state == st_load_data && !in_valid) |->
      (wr_addr == '0) && ($past(state) == st_load_data));

  a_out_len: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid [*4] |=> !out_valid);

endmodule

//--- source/kmeans_pkg.sv
package kmeans_pkg;

  // job geometry
  localparam int NUM_CLUSTERS = 4;
  localparam int NUM_POINTS   = 64;

  localparam int COORD_W = 8;
  localparam int POINT_W = 2 * COORD_W;
  localparam int DIST_W  = COORD_W + 1;
  localparam int IDX_W   = $clog2(NUM_CLUSTERS);
  localparam int ADDR_W  = $clog2(NUM_POINTS);
  // wide enough for NUM_POINTS full-scale coordinates
  localparam int SUM_W   = COORD_W + ADDR_W;
  localparam int COUNT_W = ADDR_W + 1;

  typedef logic [COORD_W-1:0] coord_t;

  // x in the upper byte, y in the lower byte
  typedef logic [POINT_W-1:0] point_t;

  typedef logic [DIST_W-1:0]  dist_t;
  typedef logic [IDX_W-1:0]   cluster_idx_t;
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [SUM_W-1:0]   sum_t;
  typedef logic [COUNT_W-1:0] count_t;

  // controller states
  typedef enum logic [2:0] {
    st_idle,
    st_load_init,
    st_load_data,
    st_assign,
    st_update,
    st_check,
    st_output
  } kmeans_state_t;

endpackage

//--- source/kmeans_top.sv
`timescale 1ns/1ps

module kmeans_top
  import kmeans_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   in_valid,
  input  point_t in_data,
  output logic   out_valid,
  output point_t out_data
);

  addr_t        mem_addr;
  logic         mem_we;
  point_t       mem_wdata;
  point_t       mem_rdata;
  logic         load_en;
  cluster_idx_t load_idx;
  logic         snapshot_en;
  logic         update_en;
  logic         acc_clear;
  logic         point_valid;
  logic         converged;
  cluster_idx_t out_sel;
  point_t       centroid0;
  point_t       centroid1;
  point_t       centroid2;
  point_t       centroid3;
  logic         assign_valid;
  cluster_idx_t assign_idx;
  point_t       assign_point;
  sum_t         sum_x0;
  sum_t         sum_x1;
  sum_t         sum_x2;
  sum_t         sum_x3;
  sum_t         sum_y0;
  sum_t         sum_y1;
  sum_t         sum_y2;
  sum_t         sum_y3;
  count_t       count0;
  count_t       count1;
  count_t       count2;
  count_t       count3;

  kmeans_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_data      (in_data),
    .mem_addr     (mem_addr),
    .mem_we       (mem_we),
    .mem_wdata    (mem_wdata),
    .load_en      (load_en),
    .load_idx     (load_idx),
    .snapshot_en  (snapshot_en),
    .update_en    (update_en),
    .acc_clear    (acc_clear),
    .point_valid  (point_valid),
    .assign_valid (assign_valid),
    .converged    (converged),
    .out_sel      (out_sel),
    .out_valid    (out_valid)
  );

  point_mem u_mem (
    .clk   (clk),
    .addr  (mem_addr),
    .we    (mem_we),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

  // initial centroids come straight off the input bus
  centroid_bank u_bank (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_en     (load_en),
    .load_idx    (load_idx),
    .load_data   (in_data),
    .snapshot_en (snapshot_en),
    .update_en   (update_en),
    .sum_x0      (sum_x0),
    .sum_x1      (sum_x1),
    .sum_x2      (sum_x2),
    .sum_x3      (sum_x3),
    .sum_y0      (sum_y0),
    .sum_y1      (sum_y1),
    .sum_y2      (sum_y2),
    .sum_y3      (sum_y3),
    .count0      (count0),
    .count1      (count1),
    .count2      (count2),
    .count3      (count3),
    .centroid0   (centroid0),
    .centroid1   (centroid1),
    .centroid2   (centroid2),
    .centroid3   (centroid3),
    .converged   (converged),
    .out_sel     (out_sel),
    .out_data    (out_data)
  );

  nearest_centroid u_scan (
    .clk          (clk),
    .rst_n        (rst_n),
    .point_valid  (point_valid),
    .point        (mem_rdata),
    .centroid0    (centroid0),
    .centroid1    (centroid1),
    .centroid2    (centroid2),
    .centroid3    (centroid3),
    .assign_valid (assign_valid),
    .assign_idx   (assign_idx),
    .assign_point (assign_point)
  );

  cluster_accum u_accum (
    .clk          (clk),
    .rst_n        (rst_n),
    .acc_clear    (acc_clear),
    .assign_valid (assign_valid),
    .assign_idx   (assign_idx),
    .assign_point (assign_point),
    .sum_x0       (sum_x0),
    .sum_x1       (sum_x1),
    .sum_x2       (sum_x2),
    .sum_x3       (sum_x3),
    .sum_y0       (sum_y0),
    .sum_y1       (sum_y1),
    .sum_y2       (sum_y2),
    .sum_y3       (sum_y3),
    .count0       (count0),
    .count1       (count1),
    .count2       (count2),
    .count3       (count3)
  );

endmodule

//--- source/nearest_centroid.sv
`timescale 1ns/1ps

module nearest_centroid
  import kmeans_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         point_valid,
  input  point_t       point,
  input  point_t       centroid0,
  input  point_t       centroid1,
  input  point_t       centroid2,
  input  point_t       centroid3,
  output logic         assign_valid,
  output cluster_idx_t assign_idx,
  output point_t       assign_point
);

  point_t       cent [NUM_CLUSTERS];
  point_t       pt_q;
  logic         busy;
  cluster_idx_t scan_idx;
  cluster_idx_t cand_idx;
  point_t       cand_point;
  dist_t        cand_dist;
  dist_t        min_dist;
  cluster_idx_t min_idx;
  logic         better;

  function automatic dist_t manhattan(point_t a, point_t b);
    coord_t dx;
    coord_t dy;
    dx = (a[15:8] > b[15:8]) ? a[15:8] - b[15:8] : b[15:8] - a[15:8];
    dy = (a[7:0] > b[7:0]) ? a[7:0] - b[7:0] : b[7:0] - a[7:0];
    return dist_t'(dx) + dist_t'(dy);
  endfunction

  assign cent = '{centroid0, centroid1, centroid2, centroid3};

  // centroid 0 is scored on the arrival cycle itself
  assign cand_idx   = point_valid ? cluster_idx_t'(0) : scan_idx;
  assign cand_point = point_valid ? point : pt_q;
  assign cand_dist  = manhattan(cand_point, cent[cand_idx]);
  // strict compare keeps the lower index on a tie
  assign better     = cand_dist < min_dist;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy         <= 1'b0;
      scan_idx     <= '0;
      assign_valid <= 1'b0;
    end else begin
      assign_valid <= busy && (scan_idx == cluster_idx_t'(NUM_CLUSTERS - 1));
      if (point_valid) begin
        busy     <= 1'b1;
        scan_idx <= cluster_idx_t'(1);
      end else if (busy) begin
        scan_idx <= scan_idx + 1'b1;
        if (scan_idx == cluster_idx_t'(NUM_CLUSTERS - 1)) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (point_valid) begin
      pt_q     <= point;
      min_dist <= cand_dist;
      min_idx  <= '0;
    end else if (busy && better) begin
      min_dist <= cand_dist;
      min_idx  <= scan_idx;
    end
    if (busy && (scan_idx == cluster_idx_t'(NUM_CLUSTERS - 1))) begin
      assign_idx   <= better ? scan_idx : min_idx;
      assign_point <= pt_q;
    end
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    point_valid |-> !busy);

endmodule

//--- source/point_mem.sv
`timescale 1ns/1ps

module point_mem
  import kmeans_pkg::*;
(
  input  logic   clk,
  input  addr_t  addr,
  input  logic   we,
  input  point_t wdata,
  output point_t rdata
);

  point_t mem [NUM_POINTS];

  // single port, read data registered
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

//--- verification/kmeans_tb.sv
`timescale 1ns/1ps

module kmeans_tb
  import kmeans_pkg::*;
();

  localparam int PASS_LIMIT      = 50;
  localparam int PASS_CYCLES     = NUM_POINTS * 5;
  localparam int JOB_TIMEOUT     = 60 * PASS_CYCLES;
  localparam int WATCHDOG_CYCLES = 20 * JOB_TIMEOUT;
  localparam int GROUP_SIZE      = NUM_POINTS / NUM_CLUSTERS;

  logic   clk;
  logic   rst_n;
  logic   in_valid;
  point_t in_data;
  logic   out_valid;
  point_t out_data;

  logic [31:0] lcg_state;
  point_t      job_init  [NUM_CLUSTERS];
  point_t      job_pts   [NUM_POINTS];
  point_t      model_out [NUM_CLUSTERS];
  point_t      exp_q [$];
  int          model_passes;
  logic        job_active;
  int          out_beat;
  int          value_errs;
  int          frame_errs;
  int          other_errs;

  kmeans_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic coord_t rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  function automatic int city_block_dist(int ax, int ay, int bx, int by);
    return ((ax > bx) ? ax - bx : bx - ax) + ((ay > by) ? ay - by : by - ay);
  endfunction

  // software k-means on job_init / job_pts, result queued for the monitor
  task automatic run_model();
    int cx  [NUM_CLUSTERS];
    int cy  [NUM_CLUSTERS];
    int sx  [NUM_CLUSTERS];
    int sy  [NUM_CLUSTERS];
    int cnt [NUM_CLUSTERS];
    int px;
    int py;
    int best;
    int best_d;
    int d;
    bit changed;
    for (int k = 0; k < NUM_CLUSTERS; k++) begin
      cx[k] = int'(job_init[k][15:8]);
      cy[k] = int'(job_init[k][7:0]);
    end
    model_passes = 0;
    changed = 1'b1;
    while (changed && model_passes < PASS_LIMIT) begin
      for (int k = 0; k < NUM_CLUSTERS; k++) begin
        sx[k]  = 0;
        sy[k]  = 0;
        cnt[k] = 0;
      end
      for (int p = 0; p < NUM_POINTS; p++) begin
        px = int'(job_pts[p][15:8]);
        py = int'(job_pts[p][7:0]);
        best = 0;
        best_d = city_block_dist(px, py, cx[0], cy[0]);
        for (int k = 1; k < NUM_CLUSTERS; k++) begin
          d = city_block_dist(px, py, cx[k], cy[k]);
          // lowest index keeps a tie
          if (d < best_d) begin
            best = k;
            best_d = d;
          end
        end
        sx[best]  += px;
        sy[best]  += py;
        cnt[best] += 1;
      end
      changed = 1'b0;
      for (int k = 0; k < NUM_CLUSTERS; k++) begin
        if (cnt[k] != 0) begin
          if (sx[k] / cnt[k] != cx[k] || sy[k] / cnt[k] != cy[k]) begin
            changed = 1'b1;
          end
          cx[k] = sx[k] / cnt[k];
          cy[k] = sy[k] / cnt[k];
        end
      end
      model_passes++;
    end
    if (changed) begin
      $display("reference model did not converge within %0d passes", PASS_LIMIT);
      other_errs++;
    end
    for (int k = 0; k < NUM_CLUSTERS; k++) begin
      model_out[k] = {coord_t'(cx[k]), coord_t'(cy[k])};
      exp_q.push_back(model_out[k]);
    end
  endtask

  task automatic make_random_job();
    coord_t px;
    coord_t py;
    for (int p = 0; p < NUM_POINTS; p++) begin
      px = rand_byte();
      py = rand_byte();
      job_pts[p] = {px, py};
    end
    for (int k = 0; k < NUM_CLUSTERS; k++) begin
      job_init[k] = job_pts[k];
    end
  endtask

  // points stay in 0..63, centroid 3 sits far out in the corner
  task automatic make_sparse_job();
    coord_t px;
    coord_t py;
    for (int p = 0; p < NUM_POINTS; p++) begin
      px = rand_byte() & 8'h3f;
      py = rand_byte() & 8'h3f;
      job_pts[p] = {px, py};
    end
    for (int k = 0; k < NUM_CLUSTERS - 1; k++) begin
      job_init[k] = job_pts[k];
    end
    job_init[NUM_CLUSTERS-1] = 16'hffff;
  endtask

  // 4x4 grids with offsets -1..2, truncated mean lands on the base
  task automatic make_grouped_job();
    coord_t bx;
    coord_t by;
    coord_t px;
    coord_t py;
    int     g;
    int     i;
    for (int p = 0; p < NUM_POINTS; p++) begin
      g  = p / GROUP_SIZE;
      i  = p % GROUP_SIZE;
      bx = (g % 2 == 1) ? 8'd200 : 8'd40;
      by = (g / 2 == 1) ? 8'd200 : 8'd40;
      px = bx + coord_t'(i % 4) - 8'd1;
      py = by + coord_t'((i / 4) % 4) - 8'd1;
      job_pts[p] = {px, py};
    end
    for (int k = 0; k < NUM_CLUSTERS; k++) begin
      bx = (k % 2 == 1) ? 8'd200 : 8'd40;
      by = (k / 2 == 1) ? 8'd200 : 8'd40;
      job_init[k] = {bx, by};
    end
  endtask

  task automatic send_job();
    @(posedge clk);
    #1;
    run_model();
    job_active = 1'b1;
    in_valid = 1'b1;
    for (int k = 0; k < NUM_CLUSTERS; k++) begin
      in_data = job_init[k];
      @(posedge clk);
      #1;
    end
    for (int p = 0; p < NUM_POINTS; p++) begin
      in_data = job_pts[p];
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
    in_data  = '0;
  endtask

  // returns during the last output beat
  task automatic wait_result(output int cycles);
    cycles = 0;
    @(negedge clk);
    while (!out_valid && cycles < JOB_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!out_valid) begin
      $display("no result within %0d cycles of the end of the job", JOB_TIMEOUT);
      other_errs++;
    end else begin
      repeat (NUM_CLUSTERS - 1) @(negedge clk);
    end
  endtask

  task automatic print_counts();
    $display("errors: value %0d, framing %0d, other %0d", value_errs, frame_errs, other_errs);
  endtask

  always @(negedge clk) begin : out_monitor
    point_t want;
    if (rst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("out_valid high with no result expected");
        other_errs++;
      end else begin
        want = exp_q.pop_front();
        a_out_data: assert (out_data === want) else begin
          $display("ERR out_data: expected %h, got %h (beat %0d)", want, out_data, out_beat);
          value_errs++;
        end
      end
      out_beat++;
      if (out_beat == NUM_CLUSTERS) begin
        out_beat = 0;
        job_active = 1'b0;
      end
    end
  end

  a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(out_valid) |-> $past(out_valid, 1) && $past(out_valid, 2) &&
      $past(out_valid, 3) && $past(out_valid, 4) && !$past(out_valid, 5))
    else begin
      $display("out_valid burst was not exactly %0d cycles long", NUM_CLUSTERS);
      frame_errs++;
    end

  a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(out_valid) |-> job_active)
    else begin
      $display("out_valid rose while no job was outstanding");
      frame_errs++;
    end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    print_counts();
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : main_seq
    int lat;
    lcg_state  = 32'h26c0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    job_active = 1'b0;
    out_beat   = 0;
    value_errs = 0;
    frame_errs = 0;
    other_errs = 0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    a_rst_valid: assert (out_valid === 1'b0) else begin
      $display("ERR out_valid: expected 0, got %h after reset", out_valid);
      value_errs++;
    end
    a_rst_data: assert (out_data === '0) else begin
      $display("ERR out_data: expected 0000, got %h after reset", out_data);
      value_errs++;
    end

    // two random jobs, the second right behind the first result
    make_random_job();
    send_job();
    wait_result(lat);
    make_random_job();
    send_job();
    wait_result(lat);

    // idle gap, then centroid 3 gets no points
    repeat (10) @(posedge clk);
    make_sparse_job();
    send_job();
    wait_result(lat);

    make_grouped_job();
    send_job();
    for (int k = 0; k < NUM_CLUSTERS; k++) begin
      a_grouped_model: assert (model_out[k] == job_init[k] && model_passes == 1) else begin
        $display("grouped job is not at its fixed point for centroid %0d", k);
        other_errs++;
      end
    end
    wait_result(lat);
    a_one_pass: assert (lat < 2 * PASS_CYCLES) else begin
      $display("converged job took %0d cycles, more than one pass", lat);
      other_errs++;
    end

    repeat (20) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d expected centroids never came out", exp_q.size());
      other_errs++;
    end
    print_counts();
    if (value_errs + frame_errs + other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
